// ==== drv_bus_req.sv ====
`timescale 1ns/1ps

module drv_bus_req #(
	parameter int unsigned TIMEOUT_CYCLES = 31
) (
	input logic clk_sys,
	input logic rst_n,
	input logic rq_valid,
	input iobus_pkg::iob_req_t rq_data,
	output logic rq_pop,
	input logic rs_full,
	output logic rs_push,
	output iobus_pkg::iob_resp_t rs_data,
	output logic dr,
	output logic dw,
	output logic din,
	output logic [3:0] dnb,
	output logic [15:0] dad,
	output logic [15:0] ddt,
	input logic rok,
	input logic rpe,
	input logic [15:0] rdt
);

	import iobus_pkg::*;

	// Wide enough to count up to the timeout
	localparam int unsigned CNT_W = $clog2(TIMEOUT_CYCLES + 1);

	typedef enum logic {
		ST_IDLE,
		ST_CYCLE
	} state_e;

	state_e state;
	iob_req_t req_q;
	logic [CNT_W-1:0] tmo_cnt;
	logic tmo_hit;
	logic cyc_end;
	logic keep_rdt;

	// New request only with room for its response
	// and once the previous push has reached the queue
	assign rq_pop = (state == ST_IDLE) && rq_valid && !rs_full && !rs_push;

	// Last cycle of the strobe when the bus stays silent
	assign tmo_hit = (tmo_cnt == CNT_W'(TIMEOUT_CYCLES - 1));
	assign cyc_end = (state == ST_CYCLE) && (rok || tmo_hit);

	// Read data only for a clean answer to read or in
	assign keep_rdt = !rpe && ((req_q.cmd == CMD_R) || (req_q.cmd == CMD_IN));

	// ------------------------------------------------------------------
	// Cycle control and strobes
	// ------------------------------------------------------------------

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			state <= ST_IDLE;
			tmo_cnt <= '0;
			dr <= 1'b0;
			dw <= 1'b0;
			din <= 1'b0;
			rs_push <= 1'b0;
		end else begin
			rs_push <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (rq_pop) begin
						state <= ST_CYCLE;
						tmo_cnt <= '0;
						// Exactly one strobe, picked by the command
						dr <= (rq_data.cmd == CMD_R);
						dw <= (rq_data.cmd == CMD_W);
						din <= (rq_data.cmd == CMD_IN);
					end
				end
				default: begin
					if (cyc_end) begin
						state <= ST_IDLE;
						dr <= 1'b0;
						dw <= 1'b0;
						din <= 1'b0;
						rs_push <= 1'b1;
					end else begin
						tmo_cnt <= tmo_cnt + CNT_W'(1);
					end
				end
			endcase
		end
	end

	// Request latched at the pop, held on the bus for the whole cycle
	always_ff @(posedge clk_sys) begin
		if (rq_pop) begin
			req_q <= rq_data;
		end
	end

	assign dnb = req_q.nb;
	assign dad = req_q.addr;
	assign ddt = req_q.data;

	// ------------------------------------------------------------------
	// Response
	// ------------------------------------------------------------------

	// Answer wins over a timeout in the same cycle
	always_ff @(posedge clk_sys) begin
		if (cyc_end) begin
			rs_data.addr <= req_q.addr;
			if (rok) begin
				rs_data.status <= rpe ? STS_PE : STS_OK;
				rs_data.data <= keep_rdt ? rdt : 16'h0000;
			end else begin
				rs_data.status <= STS_NO;
				rs_data.data <= 16'h0000;
			end
		end
	end

endmodule

// ==== iobus.f ====
iobus_pkg.sv
msg_rx.sv
msg_fifo.sv
drv_bus_req.sv
msg_tx.sv
iobus.sv
iobus_tb.sv

// ==== iobus.sv ====
`timescale 1ns/1ps

module iobus #(
	parameter int unsigned FIFO_DEPTH = 4,
	parameter int unsigned TIMEOUT_CYCLES = 31
) (
	input logic clk_sys,
	input logic rst_n,
	// Host byte stream
	input logic [7:0] in_byte,
	input logic in_valid,
	output logic [7:0] out_byte,
	output logic out_valid,
	input logic out_ready,
	// System bus
	output logic dr,
	output logic dw,
	output logic din,
	output logic [3:0] dnb,
	output logic [15:0] dad,
	output logic [15:0] ddt,
	input logic rok,
	input logic rpe,
	input logic [15:0] rdt
);

	import iobus_pkg::*;

	// ------------------------------------------------------------------
	// Request path, host to bus
	// ------------------------------------------------------------------

	logic rx_push;
	iob_req_t rx_req;
	logic rq_full;
	logic rq_valid;
	logic rq_pop;
	iob_req_t rq_data;

	msg_rx u_msg_rx (
		.clk_sys(clk_sys),
		.rst_n(rst_n),
		.in_byte(in_byte),
		.in_valid(in_valid),
		.rq_full(rq_full),
		.rq_push(rx_push),
		.rq_data(rx_req)
	);

	msg_fifo #(
		.T(iob_req_t),
		.FIFO_DEPTH(FIFO_DEPTH)
	) u_req_fifo (
		.clk_sys(clk_sys),
		.rst_n(rst_n),
		.push(rx_push),
		.push_data(rx_req),
		.full(rq_full),
		.valid(rq_valid),
		.pop(rq_pop),
		.pop_data(rq_data)
	);

	// ------------------------------------------------------------------
	// Bus cycle and response path, bus to host
	// ------------------------------------------------------------------

	logic drv_push;
	iob_resp_t drv_resp;
	logic rs_full;
	logic rs_valid;
	logic rs_pop;
	iob_resp_t rs_data;

	drv_bus_req #(
		.TIMEOUT_CYCLES(TIMEOUT_CYCLES)
	) u_drv_bus_req (
		.clk_sys(clk_sys),
		.rst_n(rst_n),
		.rq_valid(rq_valid),
		.rq_data(rq_data),
		.rq_pop(rq_pop),
		.rs_full(rs_full),
		.rs_push(drv_push),
		.rs_data(drv_resp),
		.dr(dr),
		.dw(dw),
		.din(din),
		.dnb(dnb),
		.dad(dad),
		.ddt(ddt),
		.rok(rok),
		.rpe(rpe),
		.rdt(rdt)
	);

	msg_fifo #(
		.T(iob_resp_t),
		.FIFO_DEPTH(FIFO_DEPTH)
	) u_resp_fifo (
		.clk_sys(clk_sys),
		.rst_n(rst_n),
		.push(drv_push),
		.push_data(drv_resp),
		.full(rs_full),
		.valid(rs_valid),
		.pop(rs_pop),
		.pop_data(rs_data)
	);

	msg_tx u_msg_tx (
		.clk_sys(clk_sys),
		.rst_n(rst_n),
		.rs_valid(rs_valid),
		.rs_data(rs_data),
		.rs_pop(rs_pop),
		.out_byte(out_byte),
		.out_valid(out_valid),
		.out_ready(out_ready)
	);

endmodule

// ==== iobus_pkg.sv ====
package iobus_pkg;

	// ------------------------------------------------------------------
	// Message framing
	// ------------------------------------------------------------------

	// Top bit of byte 0 tells a request from a response
	localparam logic MSG_REQ_FLAG = 1'b1;

	// Frame lengths in bytes
	// Read carries no data word, write and in carry one
	localparam logic [2:0] REQ_LEN_SHORT = 3'd4;
	localparam logic [2:0] REQ_LEN_LONG = 3'd6;
	localparam logic [2:0] RESP_LEN = 3'd5;

	// ------------------------------------------------------------------
	// Command and status codes
	// ------------------------------------------------------------------

	// Request commands, low nibble of the command byte
	typedef enum logic [3:0] {
		CMD_W = 4'b0010,
		CMD_R = 4'b0011,
		CMD_IN = 4'b0110
	} iob_cmd_e;

	// Response status, low nibble of the response byte 0
	typedef enum logic [3:0] {
		// Bus answered busy, kept for the code space only
		STS_EN = 4'b0001,
		STS_OK = 4'b0010,
		STS_PE = 4'b0011,
		// Timeout with no answer from the bus
		STS_NO = 4'b0100
	} iob_status_e;

	// ------------------------------------------------------------------
	// Queue payloads
	// ------------------------------------------------------------------

	// Request as decoded from a host frame, 40 bits
	typedef struct packed {
		iob_cmd_e cmd;
		logic [3:0] nb;
		logic [15:0] addr;
		// Zero for a read
		logic [15:0] data;
	} iob_req_t;

	// Response built at the end of a bus cycle, 36 bits
	typedef struct packed {
		iob_status_e status;
		logic [15:0] addr;
		// Read data for an ok read or in, zero otherwise
		logic [15:0] data;
	} iob_resp_t;

endpackage

// ==== iobus_tb.sv ====
`timescale 1ns/1ps

module iobus_tb;

	import iobus_pkg::*;

	localparam int FIFO_DEPTH = 4;
	localparam int TIMEOUT_CYCLES = 31;
	// Test data layout, one record of 16 bytes per request frame
	localparam int REC_BYTES = 16;
	localparam int MAX_REC = 32;
	// Responder behavior per request
	localparam logic [1:0] MODE_OK = 2'd0;
	localparam logic [1:0] MODE_PE = 2'd1;
	localparam logic [1:0] MODE_NEVER = 2'd2;

	// What the bus should see for one request, and how to answer it
	typedef struct packed {
		iob_req_t req;
		logic [1:0] mode;
	} bus_exp_t;

	logic clk_sys;
	logic rst_n;
	logic [7:0] in_byte;
	logic in_valid;
	logic [7:0] out_byte;
	logic out_valid;
	logic out_ready;
	logic dr;
	logic dw;
	logic din;
	logic [3:0] dnb;
	logic [15:0] dad;
	logic [15:0] ddt;
	logic rok;
	logic rpe;
	logic [15:0] rdt;

	logic [7:0] tdata [MAX_REC * REC_BYTES];
	bus_exp_t bus_exp [$];
	iob_resp_t resp_exp [$];
	int errors = 0;
	int checks = 0;
	int tests = 0;
	int resp_wanted = 0;
	int resp_done = 0;
	int cycle_cnt = 0;
	int cycle_limit = 100000;
	int n_rec;

	// Responder state
	logic [15:0] bus_mem [256];
	bus_exp_t bus_cur;
	logic bus_busy = 1'b0;
	logic bus_answered = 1'b0;
	int bus_cnt;
	int bus_wait;
	logic [31:0] bus_seed = 32'hc71b6d4e;
	logic [31:0] rdy_seed = 32'hc71b6d4e ^ 32'h5bd1e995;

	// Collector for host output bytes
	logic [7:0] frame_buf [5];
	int frame_pos = 0;

	iobus #(
		.FIFO_DEPTH(FIFO_DEPTH),
		.TIMEOUT_CYCLES(TIMEOUT_CYCLES)
	) u_iobus (
		.clk_sys(clk_sys),
		.rst_n(rst_n),
		.in_byte(in_byte),
		.in_valid(in_valid),
		.out_byte(out_byte),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.dr(dr),
		.dw(dw),
		.din(din),
		.dnb(dnb),
		.dad(dad),
		.ddt(ddt),
		.rok(rok),
		.rpe(rpe),
		.rdt(rdt)
	);

	// 20 ns clock
	always begin
		#10 clk_sys = ~clk_sys;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// One-hot strobe pattern {dr, dw, din} for a command
	function automatic logic [2:0] strobe_for_cmd(input iob_cmd_e cmd);
		case (cmd)
			CMD_R: return 3'b100;
			CMD_W: return 3'b010;
			default: return 3'b001;
		endcase
	endfunction

	// ------------------------------------------------------------------
	// Compare tasks
	// ------------------------------------------------------------------

	task automatic check_status(input string name, input iob_status_e got,
		input iob_status_e exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error at %0d ns: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_word(input string name, input logic [15:0] got,
		input logic [15:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error at %0d ns: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic report_failure(input string what);
		errors++;
		$display("Error at %0d ns: %s", $time, what);
	endtask

	// ------------------------------------------------------------------
	// Bus responder model
	// ------------------------------------------------------------------

	// New strobe, compare it with the oldest pending request
	task automatic start_bus_cycle();
		if (bus_exp.size() == 0) begin
			report_failure("bus cycle started with no request pending");
			bus_cur = '0;
		end else begin
			bus_cur = bus_exp.pop_front();
			check_word("{dr,dw,din}", {13'h0000, dr, dw, din},
				{13'h0000, strobe_for_cmd(bus_cur.req.cmd)});
			check_word("dnb", {12'h000, dnb}, {12'h000, bus_cur.req.nb});
			check_word("dad", dad, bus_cur.req.addr);
			if (bus_cur.req.cmd != CMD_R) begin
				check_word("ddt", ddt, bus_cur.req.data);
			end
		end
		// Answer time stays well below the driver timeout
		bus_seed = lcg_next(bus_seed);
		bus_wait = int'(bus_seed[31:16]) % (TIMEOUT_CYCLES - 4);
		bus_cnt = 0;
		bus_busy = 1'b1;
		bus_answered = 1'b0;
	endtask

	task automatic bus_step();
		logic strobe;
		logic [7:0] idx;
		strobe = dr || dw || din;
		idx = dad[7:0];
		rok = 1'b0;
		rpe = 1'b0;
		rdt = 16'h0000;
		if (!rst_n) begin
			bus_busy = 1'b0;
		end else if (bus_busy && bus_answered) begin
			// Strobe must be gone one cycle after rok
			if (strobe) begin
				report_failure("bus strobe still high one cycle after rok");
			end
			bus_busy = 1'b0;
		end else if (bus_busy && !strobe) begin
			if (bus_cur.mode != MODE_NEVER) begin
				report_failure("bus strobe dropped before the bus answered");
			end else if (bus_cnt < TIMEOUT_CYCLES - 2) begin
				report_failure("bus strobe dropped too early for a timeout");
			end
			bus_busy = 1'b0;
		end else if (bus_busy) begin
			if (bus_cur.mode != MODE_NEVER && bus_cnt == bus_wait) begin
				rok = 1'b1;
				rpe = (bus_cur.mode == MODE_PE);
				if (dr || din) begin
					rdt = bus_mem[idx];
				end
				// Writes and in cycles update the memory after the read out
				if (bus_cur.mode == MODE_OK && (dw || din)) begin
					bus_mem[idx] = ddt;
				end
				bus_answered = 1'b1;
			end else begin
				bus_cnt++;
				if (bus_cnt > TIMEOUT_CYCLES + 2) begin
					report_failure("bus strobe held past the timeout");
					bus_busy = 1'b0;
				end
			end
		end else if (strobe) begin
			start_bus_cycle();
		end
	endtask

	always begin
		@(posedge clk_sys);
		#1;
		bus_step();
	end

	// Random back-pressure on the host output, high about 3 cycles in 4
	always begin
		@(posedge clk_sys);
		#1;
		rdy_seed = lcg_next(rdy_seed);
		out_ready = (rdy_seed[31:30] != 2'b00);
	end

	// ------------------------------------------------------------------
	// Response collector, samples midway between edges
	// ------------------------------------------------------------------

	task automatic check_frame();
		iob_resp_t exp;
		if (resp_exp.size() == 0) begin
			report_failure("response frame arrived with none expected");
		end else begin
			exp = resp_exp.pop_front();
			check_word("out_byte[7:4] of byte 0", {12'h000, frame_buf[0][7:4]}, 16'h0000);
			check_status("status", iob_status_e'(frame_buf[0][3:0]), exp.status);
			check_word("addr echo", {frame_buf[1], frame_buf[2]}, exp.addr);
			check_word("data", {frame_buf[3], frame_buf[4]}, exp.data);
		end
		resp_done++;
	endtask

	always @(negedge clk_sys) begin
		if (rst_n && out_valid && out_ready) begin
			frame_buf[frame_pos] = out_byte;
			if (frame_pos == 4) begin
				check_frame();
				frame_pos = 0;
			end else begin
				frame_pos++;
			end
		end
	end

	// Run limit
	always @(posedge clk_sys) begin
		cycle_cnt++;
		if (cycle_cnt > cycle_limit) begin
			$display("Run stopped after %0d cycles with tests still open", cycle_cnt);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	// ------------------------------------------------------------------
	// Stimulus
	// ------------------------------------------------------------------

	// Bytes go out on consecutive cycles, in_valid stays high across frames
	task automatic send_frame(input int base, input int len);
		for (int i = 0; i < len; i++) begin
			@(posedge clk_sys);
			#1;
			in_byte = tdata[base + 2 + i];
			in_valid = 1'b1;
		end
	endtask

	task automatic run_record(input int r);
		int base;
		int len;
		bus_exp_t bexp;
		iob_resp_t rexp;
		base = r * REC_BYTES;
		len = int'(tdata[base + 1]);
		if (tdata[base + 9] != 8'h00) begin
			bexp.req.cmd = iob_cmd_e'(tdata[base + 2][3:0]);
			bexp.req.nb = tdata[base + 3][3:0];
			bexp.req.addr = {tdata[base + 4], tdata[base + 5]};
			bexp.req.data = (len == 6) ? {tdata[base + 6], tdata[base + 7]} : 16'h0000;
			bexp.mode = tdata[base + 8][1:0];
			bus_exp.push_back(bexp);
			rexp.status = iob_status_e'(tdata[base + 10][3:0]);
			rexp.addr = {tdata[base + 11], tdata[base + 12]};
			rexp.data = {tdata[base + 13], tdata[base + 14]};
			resp_exp.push_back(rexp);
			resp_wanted++;
		end
		send_frame(base, len);
		if (tdata[base + 15] != 8'h00) begin
			@(posedge clk_sys);
			#1;
			in_valid = 1'b0;
			in_byte = 8'h00;
			while (resp_done < resp_wanted) begin
				@(posedge clk_sys);
			end
			tests++;
			$display("Test %0d finished at %0d ns, %0d errors so far",
				tdata[base], $time, errors);
		end
	endtask

	initial begin
		clk_sys = 1'b0;
		rst_n = 1'b0;
		in_byte = 8'h00;
		in_valid = 1'b0;
		out_ready = 1'b0;
		rok = 1'b0;
		rpe = 1'b0;
		rdt = 16'h0000;
		// Unwritten locations read back a pattern of their own index
		for (int i = 0; i < 256; i++) begin
			bus_mem[i] = {~i[7:0], i[7:0]};
		end
		$readmemh("iobus_testdata.txt", tdata);
		n_rec = 0;
		while (n_rec < MAX_REC && !$isunknown(tdata[n_rec * REC_BYTES]) &&
			tdata[n_rec * REC_BYTES] != 8'hff) begin
			n_rec++;
		end
		if (n_rec == 0) begin
			report_failure("no test records loaded from iobus_testdata.txt");
		end
		// Worst case per frame, plus the idle drain at the end
		cycle_limit = n_rec * (6 + TIMEOUT_CYCLES + 5 * 8) + 4 * TIMEOUT_CYCLES + 100;

		repeat (3) @(posedge clk_sys);
		#1;
		rst_n = 1'b1;

		for (int r = 0; r < n_rec; r++) begin
			run_record(r);
		end
		@(posedge clk_sys);
		#1;
		in_valid = 1'b0;

		// Idle time so stray frames or bus cycles show up
		repeat (2 * TIMEOUT_CYCLES) @(posedge clk_sys);
		if (resp_exp.size() != 0 || bus_exp.size() != 0 || frame_pos != 0 || bus_busy) begin
			report_failure("requests or response bytes left over at the end of the run");
		end

		$display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

// ==== iobus_testdata.txt ====
// id len | request bytes b0..b5 | mode exp | response bytes r0..r4 | wait
// mode 00 answers ok after a random delay, 01 answers with rpe, 02 never answers
// exp 01 means a response frame is expected, wait 01 waits for all responses
01 06 82 03 12 34 be ef 00 01 02 12 34 00 00 00
01 04 83 05 12 34 00 00 00 01 02 12 34 be ef 01
// in cycle with no bus answer
02 06 86 01 0a 50 11 11 02 01 04 0a 50 00 00 01
// read answered with a parity error
03 04 83 02 00 77 00 00 01 01 03 00 77 00 00 01
// unflagged and unknown command bytes are dropped
04 04 03 01 00 22 00 00 00 00 00 00 00 00 00 00
04 04 85 01 00 22 00 00 00 00 00 00 00 00 00 00
04 04 83 07 12 34 00 00 00 01 02 12 34 be ef 01
// back to back frames under random back-pressure
05 06 82 00 20 01 0a 0b 00 01 02 20 01 00 00 00
05 06 86 04 20 40 55 55 00 01 02 20 40 bf 40 00
05 04 83 09 20 01 00 00 00 01 02 20 01 0a 0b 00
05 04 83 0f 30 40 00 00 00 01 02 30 40 55 55 00
05 04 83 06 21 c3 00 00 00 01 02 21 c3 3c c3 01
// end of records
ff 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00

// ==== msg_fifo.sv ====
`timescale 1ns/1ps

module msg_fifo #(
	parameter type T = logic [7:0],
	// Power of two, at least 2
	parameter int unsigned FIFO_DEPTH = 4
) (
	input logic clk_sys,
	input logic rst_n,
	input logic push,
	input T push_data,
	output logic full,
	output logic valid,
	input logic pop,
	output T pop_data
);

	localparam int unsigned AW = $clog2(FIFO_DEPTH);
	localparam int unsigned CW = AW + 1;

	T mem [FIFO_DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	// One extra bit so a full queue is told apart from an empty one
	logic [CW-1:0] count;
	logic do_push;
	logic do_pop;

	assign full = (count == CW'(FIFO_DEPTH));
	assign valid = (count != '0);

	// Writes into a full queue and pops from an empty one are ignored
	assign do_push = push && !full;
	assign do_pop = pop && valid;

	// Storage, no reset on the payload
	always_ff @(posedge clk_sys) begin
		if (do_push) begin
			mem[wr_ptr] <= push_data;
		end
	end

	// Pointers wrap on their own since the depth is a power of two
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Head of queue shown without a pop
	assign pop_data = mem[rd_ptr];

endmodule

// ==== msg_rx.sv ====
`timescale 1ns/1ps

module msg_rx (
	input logic clk_sys,
	input logic rst_n,
	input logic [7:0] in_byte,
	input logic in_valid,
	input logic rq_full,
	output logic rq_push,
	output iobus_pkg::iob_req_t rq_data
);

	import iobus_pkg::*;

	// Byte position inside the current frame, zero means waiting for a command
	logic [2:0] byte_cnt;
	logic [2:0] frame_len;
	logic cmd_ok;
	logic last_byte;
	iob_cmd_e in_cmd;
	iob_req_t req_q;

	assign in_cmd = iob_cmd_e'(in_byte[3:0]);

	// Command byte must carry the request flag, three zero bits and a known code
	always_comb begin
		cmd_ok = (in_byte[7] == MSG_REQ_FLAG) && (in_byte[6:4] == 3'b000) &&
			((in_byte[3:0] == CMD_R) || (in_byte[3:0] == CMD_W) ||
			(in_byte[3:0] == CMD_IN));
	end

	assign last_byte = (byte_cnt == frame_len - 3'd1);

	// Byte counter and push pulse
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			byte_cnt <= 3'd0;
			frame_len <= REQ_LEN_SHORT;
			rq_push <= 1'b0;
		end else begin
			rq_push <= 1'b0;
			if (in_valid) begin
				if (byte_cnt == 3'd0) begin
					// Unknown or unflagged bytes are simply skipped
					if (cmd_ok) begin
						byte_cnt <= 3'd1;
						frame_len <= (in_cmd == CMD_R) ? REQ_LEN_SHORT : REQ_LEN_LONG;
					end
				end else if (last_byte) begin
					byte_cnt <= 3'd0;
					// Frame is lost when the queue has no room
					rq_push <= !rq_full;
				end else begin
					byte_cnt <= byte_cnt + 3'd1;
				end
			end
		end
	end

	// Field assembly, multi-byte fields arrive high byte first
	always_ff @(posedge clk_sys) begin
		if (in_valid) begin
			case (byte_cnt)
				3'd0: begin
					req_q.cmd <= in_cmd;
					// Reads never overwrite the data word
					req_q.data <= 16'h0000;
				end
				3'd1: req_q.nb <= in_byte[3:0];
				3'd2: req_q.addr[15:8] <= in_byte;
				3'd3: req_q.addr[7:0] <= in_byte;
				3'd4: req_q.data[15:8] <= in_byte;
				default: req_q.data[7:0] <= in_byte;
			endcase
		end
	end

	assign rq_data = req_q;

endmodule

// ==== msg_tx.sv ====
`timescale 1ns/1ps

module msg_tx (
	input logic clk_sys,
	input logic rst_n,
	input logic rs_valid,
	input iobus_pkg::iob_resp_t rs_data,
	output logic rs_pop,
	output logic [7:0] out_byte,
	output logic out_valid,
	input logic out_ready
);

	import iobus_pkg::*;

	iob_resp_t resp_q;
	// Index of the byte now on out_byte
	logic [2:0] byte_idx;
	logic busy;
	logic hs;
	logic last_hs;

	assign hs = out_valid && out_ready;
	assign last_hs = hs && (byte_idx == RESP_LEN - 3'd1);

	// Next response is taken when idle or as the last byte leaves
	assign rs_pop = rs_valid && (!busy || last_hs);

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			busy <= 1'b0;
			byte_idx <= 3'd0;
		end else begin
			if (rs_pop) begin
				busy <= 1'b1;
				byte_idx <= 3'd0;
			end else if (last_hs) begin
				busy <= 1'b0;
				byte_idx <= 3'd0;
			end else if (hs) begin
				byte_idx <= byte_idx + 3'd1;
			end
		end
	end

	// Response payload, held for the whole frame
	always_ff @(posedge clk_sys) begin
		if (rs_pop) begin
			resp_q <= rs_data;
		end
	end

	assign out_valid = busy;

	// ------------------------------------------------------------------
	// Frame layout
	// ------------------------------------------------------------------

	// Byte 0 has a clear top bit, which marks a response
	always_comb begin
		case (byte_idx)
			3'd0: out_byte = {1'b0, 3'b000, resp_q.status};
			3'd1: out_byte = resp_q.addr[15:8];
			3'd2: out_byte = resp_q.addr[7:0];
			3'd3: out_byte = resp_q.data[15:8];
			3'd4: out_byte = resp_q.data[7:0];
			default: out_byte = 8'h00;
		endcase
	end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the iobus testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module iobus_tb -f iobus.f -o iobus_sim

sim_out=$(./obj_dir/iobus_sim)
echo "$sim_out"

if echo "$sim_out" | grep -q "^TESTBENCH PASSED$"; then
	exit 0
fi
exit 1
